// File: Bender.yml
package:
  name: rv_exec_slice

sources:
  - include_dirs:
      - src
    files:
      - src/rvPkg.sv
      - src/controlUnit.sv
      - src/immGen.sv
      - src/regFile.sv
      - src/aluUnit.sv
      - src/branchUnit.sv
      - src/rvExecTop.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/clkGen.sv
      - sim/rvExecTb.sv

// File: compile.f
+incdir+src
src/rvPkg.sv
src/controlUnit.sv
src/immGen.sv
src/regFile.sv
src/aluUnit.sv
src/branchUnit.sv
src/rvExecTop.sv
sim/clkGen.sv
sim/rvExecTb.sv

// File: sim/clkGen.sv
`default_nettype none

module clkGen #(
	parameter int periodNs = 20,
	parameter int resetCycles = 5
) (
	output logic clk,
	output logic rstN
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk; // Free running
	end

	initial begin
		rstN = 1'b0; // Held low from time zero
		repeat (resetCycles) @(posedge clk);
		#2 rstN = 1'b1; // Released off the edge
	end

endmodule

`default_nettype wire

// File: sim/rvExecTb.sv
`default_nettype none

`include "rvSettings.svh"

module rvExecTb;
	timeunit 1ns;
	timeprecision 1ps;
	import rvPkg::*;

	localparam int maxRows = 64;
	localparam int driveDelay = 2; // ns after rising edge
	localparam int timeoutMargin = 20;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opJalr = 7'b1100111;
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opAuipc = 7'b0010111;

	logic clk, rstN, instrValid, resultValid, rdWrite, memRead, memWrite;
	wordT instr, pc, rdData, memAddr, storeData, nextPc;
	regAddrT rdAddr;
	memTypeT memType;

	// Stimulus and expected-value table
	string rowName [maxRows];
	logic rowValid [maxRows], expRdWrite [maxRows], expMemRead [maxRows], expMemWrite [maxRows];
	wordT rowInstr [maxRows], rowPc [maxRows], expRdData [maxRows], expMemAddr [maxRows];
	wordT expStoreData [maxRows], expNextPc [maxRows];
	regAddrT expRdAddr [maxRows];
	memTypeT expMemType [maxRows];
	int numRows = 0;
	wordT pcNow = 32'h0000_0100; // PC given to the next row
	int valueErrors = 0;
	int handshakeErrors = 0;
	int cycleCount = 0;

	clkGen clkGen_i (.clk(clk), .rstN(rstN));

	rvExecTop dut_i (
		.clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr), .pc(pc),
		.resultValid(resultValid), .rdWrite(rdWrite), .memRead(memRead), .memWrite(memWrite),
		.rdAddr(rdAddr), .rdData(rdData), .memAddr(memAddr), .storeData(storeData),
		.nextPc(nextPc), .memType(memType)
	);

	//////////////////////////////////////////////////
	// RV32I encoders
	//////////////////////////////////////////////////
	function automatic wordT iFormat(input logic [11:0] imm, input regAddrT rs1,
		input logic [2:0] f3, input regAddrT rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic wordT rFormat(input logic [6:0] f7, input regAddrT rs2,
		input regAddrT rs1, input logic [2:0] f3, input regAddrT rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic wordT sFormat(input logic [11:0] imm, input regAddrT rs2,
		input regAddrT rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic wordT bFormat(input logic [12:0] imm, input regAddrT rs2,
		input regAddrT rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011}; // Scrambled
	endfunction

	function automatic wordT uFormat(input logic [19:0] imm, input regAddrT rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic wordT jFormat(input logic [20:0] imm, input regAddrT rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	//////////////////////////////////////////////////
	// Table rows
	//////////////////////////////////////////////////
	task automatic putRow(input string name, input logic valid, input wordT ins, input logic wr,
		input wordT rdV, input logic mr, input logic mw, input memTypeT mt, input wordT addr,
		input wordT sd, input wordT npc);
		rowName[numRows] = name;
		rowValid[numRows] = valid;
		rowInstr[numRows] = ins;
		rowPc[numRows] = pcNow;
		expRdWrite[numRows] = wr;
		expRdAddr[numRows] = ins[11:7]; // rd field
		expRdData[numRows] = rdV;
		expMemRead[numRows] = mr;
		expMemWrite[numRows] = mw;
		expMemType[numRows] = mt;
		expMemAddr[numRows] = addr;
		expStoreData[numRows] = sd;
		expNextPc[numRows] = npc;
		numRows++;
		pcNow = pcNow + `RV_PC_INC;
	endtask

	task automatic aluRow(input string name, input wordT ins, input wordT rdV);
		putRow(name, 1'b1, ins, 1'b1, rdV, 1'b0, 1'b0, memByte, '0, '0, pcNow + `RV_PC_INC);
	endtask

	task automatic jumpRow(input string name, input wordT ins, input wordT target);
		putRow(name, 1'b1, ins, 1'b1, pcNow + `RV_PC_INC, 1'b0, 1'b0, memByte, '0, '0, target);
	endtask

	task automatic branchRow(input string name, input wordT ins, input wordT target);
		putRow(name, 1'b1, ins, 1'b0, '0, 1'b0, 1'b0, memByte, '0, '0, target);
	endtask

	task automatic memRow(input string name, input wordT ins, input logic isStore,
		input memTypeT mt, input wordT addr, input wordT sd);
		putRow(name, 1'b1, ins, 1'b0, '0, !isStore, isStore, mt, addr, sd, pcNow + `RV_PC_INC);
	endtask

	// Instruction on the bus with no strobe, must have no effect
	task automatic idleRow(input string name, input wordT ins);
		putRow(name, 1'b0, ins, 1'b0, '0, 1'b0, 1'b0, memByte, '0, '0, '0);
	endtask

	task automatic fillTable();
		aluRow("addi x1", iFormat(12'h005, 5'd0, 3'b000, 5'd1, opImm), 32'd5);
		aluRow("addi x2 neg", iFormat(12'hFFD, 5'd0, 3'b000, 5'd2, opImm), 32'hFFFF_FFFD);
		aluRow("addi x3 min", iFormat(12'h800, 5'd0, 3'b000, 5'd3, opImm), 32'hFFFF_F800);
		aluRow("addi x4 max", iFormat(12'h7FF, 5'd0, 3'b000, 5'd4, opImm), 32'h0000_07FF);
		aluRow("andi x9", iFormat(12'h0F3, 5'd4, 3'b111, 5'd9, opImm), 32'h0000_00F3); // Uses x4
		aluRow("slti x5", iFormat(12'h001, 5'd2, 3'b010, 5'd5, opImm), 32'd1);
		aluRow("sltiu x6", iFormat(12'h001, 5'd2, 3'b011, 5'd6, opImm), 32'd0);
		aluRow("xori x7", iFormat(12'h0F0, 5'd1, 3'b100, 5'd7, opImm), 32'h0000_00F5);
		aluRow("ori x8", iFormat(12'h100, 5'd1, 3'b110, 5'd8, opImm), 32'h0000_0105);
		aluRow("slli x10", iFormat(12'h004, 5'd1, 3'b001, 5'd10, opImm), 32'h0000_0050);
		aluRow("srli x11", iFormat(12'h004, 5'd2, 3'b101, 5'd11, opImm), 32'h0FFF_FFFF);
		aluRow("srai x12", iFormat(12'h401, 5'd2, 3'b101, 5'd12, opImm), 32'hFFFF_FFFE);
		idleRow("idle addi x1", iFormat(12'h063, 5'd0, 3'b000, 5'd1, opImm)); // x1 stays 5
		aluRow("add x13", rFormat(7'h00, 5'd2, 5'd1, 3'b000, 5'd13), 32'd2);
		aluRow("sub x14", rFormat(7'h20, 5'd2, 5'd1, 3'b000, 5'd14), 32'd8);
		aluRow("sll x15", rFormat(7'h00, 5'd1, 5'd1, 3'b001, 5'd15), 32'h0000_00A0);
		aluRow("slt x16", rFormat(7'h00, 5'd1, 5'd2, 3'b010, 5'd16), 32'd1); // -3 < 5
		aluRow("sltu x17", rFormat(7'h00, 5'd1, 5'd2, 3'b011, 5'd17), 32'd0);
		aluRow("xor x18", rFormat(7'h00, 5'd7, 5'd1, 3'b100, 5'd18), 32'h0000_00F0);
		aluRow("srl x19", rFormat(7'h00, 5'd1, 5'd3, 3'b101, 5'd19), 32'h07FF_FFC0);
		aluRow("sra x20", rFormat(7'h20, 5'd1, 5'd3, 3'b101, 5'd20), 32'hFFFF_FFC0);
		aluRow("or x21", rFormat(7'h00, 5'd4, 5'd1, 3'b110, 5'd21), 32'h0000_07FF);
		aluRow("and x22", rFormat(7'h00, 5'd4, 5'd2, 3'b111, 5'd22), 32'h0000_07FD);
		aluRow("lui x23", uFormat(20'h12345, 5'd23, opLui), 32'h1234_5000);
		aluRow("auipc x24", uFormat(20'h00001, 5'd24, opAuipc), pcNow + 32'h0000_1000);
		aluRow("addi x0", iFormat(12'h007, 5'd1, 3'b000, 5'd0, opImm), 32'd12);
		aluRow("add x25 from x0", rFormat(7'h00, 5'd1, 5'd0, 3'b000, 5'd25), 32'd5); // x0 still 0
		jumpRow("jal x26", jFormat(21'd16, 5'd26), pcNow + 32'd16);
		jumpRow("jalr x27", iFormat(12'h010, 5'd1, 3'b000, 5'd27, opJalr), 32'h0000_0014);
		branchRow("beq taken", bFormat(13'd8, 5'd1, 5'd1, 3'b000), pcNow + 32'd8);
		branchRow("beq not taken", bFormat(13'd8, 5'd2, 5'd1, 3'b000), pcNow + `RV_PC_INC);
		branchRow("bne taken", bFormat(13'h1FF0, 5'd2, 5'd1, 3'b001), pcNow - 32'd16);
		branchRow("bne not taken", bFormat(13'd8, 5'd1, 5'd1, 3'b001), pcNow + `RV_PC_INC);
		branchRow("blt taken", bFormat(13'd12, 5'd1, 5'd2, 3'b100), pcNow + 32'd12);
		branchRow("blt not taken", bFormat(13'd12, 5'd2, 5'd1, 3'b100), pcNow + `RV_PC_INC);
		branchRow("bge taken", bFormat(13'd20, 5'd2, 5'd1, 3'b101), pcNow + 32'd20);
		branchRow("bge not taken", bFormat(13'd20, 5'd1, 5'd2, 3'b101), pcNow + `RV_PC_INC);
		branchRow("bltu taken", bFormat(13'd24, 5'd2, 5'd1, 3'b110), pcNow + 32'd24);
		branchRow("bltu not taken", bFormat(13'd24, 5'd1, 5'd2, 3'b110), pcNow + `RV_PC_INC);
		branchRow("bgeu taken", bFormat(13'h1FF8, 5'd1, 5'd2, 3'b111), pcNow - 32'd8);
		branchRow("bgeu not taken", bFormat(13'h1FF8, 5'd2, 5'd1, 3'b111), pcNow + `RV_PC_INC);
		idleRow("idle sw", sFormat(12'h000, 5'd1, 5'd2, 3'b010));
		idleRow("idle lw", iFormat(12'h000, 5'd1, 3'b010, 5'd3, opLoad));
		memRow("sw", sFormat(12'h008, 5'd2, 5'd1, 3'b010), 1'b1, memWord, 32'hD, 32'hFFFF_FFFD);
		memRow("sb", sFormat(12'hFFC, 5'd1, 5'd4, 3'b000), 1'b1, memByte, 32'h7FB, 32'd5);
		memRow("sh", sFormat(12'h002, 5'd7, 5'd23, 3'b001), 1'b1, memHalf, 32'h1234_5002, 32'hF5);
		memRow("lw x28", iFormat(12'h004, 5'd1, 3'b010, 5'd28, opLoad), 1'b0, memWord, 32'd9, '0);
		memRow("lbu x29", iFormat(12'hFFF, 5'd23, 3'b100, 5'd29, opLoad), 1'b0, memByteU,
			32'h1234_4FFF, '0);
		memRow("lhu x30", iFormat(12'h006, 5'd1, 3'b101, 5'd30, opLoad), 1'b0, memHalfU, 32'hB, '0);
		aluRow("add x31 after load", rFormat(7'h00, 5'd1, 5'd28, 3'b000, 5'd31), 32'd5); // x28 unwritten
		idleRow("idle", '0);
	endtask

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////
	task automatic checkWord(input string name, input string field, input wordT exp, input wordT act);
		if (act !== exp) begin
			valueErrors++;
			$display("error %s %s: expected %h actual %h", name, field, exp, act);
		end
	endtask

	task automatic checkAddr(input string name, input regAddrT exp, input regAddrT act);
		if (act !== exp) begin
			valueErrors++;
			$display("error %s rdAddr: expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic checkMemType(input string name, input memTypeT exp, input memTypeT act);
		if (act !== exp) begin
			valueErrors++;
			$display("error %s memType: expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic checkFlag(input string name, input string field, input logic exp, input logic act);
		if (act !== exp) begin
			valueErrors++;
			$display("error %s %s: expected %b actual %b", name, field, exp, act);
		end
	endtask

	task automatic checkRow(input int i);
		if (!rowValid[i]) begin
			if (resultValid !== 1'b0) begin // Idle cycle must stay quiet
				handshakeErrors++;
				$display("resultValid was raised after a cycle with no instruction (%s)",
					rowName[i]);
			end
			checkFlag(rowName[i], "rdWrite", expRdWrite[i], rdWrite); // Gated by the strobe
			checkFlag(rowName[i], "memRead", expMemRead[i], memRead);
			checkFlag(rowName[i], "memWrite", expMemWrite[i], memWrite);
		end else if (resultValid !== 1'b1) begin
			handshakeErrors++;
			$display("resultValid did not come one cycle after %s", rowName[i]);
		end else begin
			checkFlag(rowName[i], "rdWrite", expRdWrite[i], rdWrite);
			checkFlag(rowName[i], "memRead", expMemRead[i], memRead);
			checkFlag(rowName[i], "memWrite", expMemWrite[i], memWrite);
			if (expRdWrite[i]) begin
				checkAddr(rowName[i], expRdAddr[i], rdAddr);
				checkWord(rowName[i], "rdData", expRdData[i], rdData);
			end
			if (expMemRead[i] || expMemWrite[i]) begin
				checkWord(rowName[i], "memAddr", expMemAddr[i], memAddr);
				checkMemType(rowName[i], expMemType[i], memType);
			end
			if (expMemWrite[i]) checkWord(rowName[i], "storeData", expStoreData[i], storeData);
			checkWord(rowName[i], "nextPc", expNextPc[i], nextPc);
		end
	endtask

	//////////////////////////////////////////////////
	// Run
	//////////////////////////////////////////////////
	initial begin
		instrValid = 1'b0;
		instr = '0;
		pc = '0;
		fillTable();
		wait (rstN === 1'b1);
		@(posedge clk);
		#driveDelay;
		for (int i = 0; i < numRows; i++) begin
			instrValid = rowValid[i];
			instr = rowInstr[i];
			pc = rowPc[i];
			@(posedge clk);
			#driveDelay; // Outputs settled
			checkRow(i);
		end
		instrValid = 1'b0;
		$display("value errors: %0d, handshake errors: %0d", valueErrors, handshakeErrors);
		if (valueErrors + handshakeErrors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// Watchdog, bound by table length
	always @(posedge clk) begin
		cycleCount++;
		if (numRows > 0 && cycleCount >= numRows + timeoutMargin) begin
			$display("timeout: run did not finish within %0d cycles", cycleCount);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: src/aluUnit.sv
`default_nettype none

module aluUnit (
	input  wire rvPkg::aluOpT op,
	input  wire rvPkg::wordT  a,
	input  wire rvPkg::wordT  b,
	output rvPkg::wordT       y
);
	import rvPkg::*;

	logic [4:0] shamt; // Shift amount
	logic       ltSigned;
	logic       ltUnsigned;

	assign shamt = b[4:0];
	assign ltSigned = $signed(a) < $signed(b);
	assign ltUnsigned = a < b;

	//////////////////////////////////////////////////
	// Operation select
	//////////////////////////////////////////////////
	always_comb begin
		case (op)
			aluAdd:  y = a + b;
			aluSub:  y = a - b;
			aluSll:  y = a << shamt;
			aluSlt:  y = wordT'(ltSigned); // 0 or 1
			aluSltu: y = wordT'(ltUnsigned);
			aluXor:  y = a ^ b;
			aluSrl:  y = a >> shamt; // Logical, zero fill
			aluSra:  y = wordT'($signed(a) >>> shamt); // Sign fill
			aluOr:   y = a | b;
			aluAnd:  y = a & b;
			default: y = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: src/branchUnit.sv
`default_nettype none

`include "rvSettings.svh"

module branchUnit (
	input  wire [2:0]        funct3,
	input  wire              branch,
	input  wire              jump,
	input  wire rvPkg::wordT rs1Data,
	input  wire rvPkg::wordT rs2Data,
	input  wire rvPkg::wordT aluY, // Jump target sum
	input  wire rvPkg::wordT pc,
	input  wire rvPkg::wordT imm,
	output rvPkg::wordT      nextPc
);
	import rvPkg::*;

	logic taken; // Branch condition met
	wordT jumpTarget;

	always_comb begin
		case (funct3)
			3'b000: taken = rs1Data == rs2Data; // BEQ
			3'b001: taken = rs1Data != rs2Data; // BNE
			3'b100: taken = $signed(rs1Data) < $signed(rs2Data); // BLT
			3'b101: taken = $signed(rs1Data) >= $signed(rs2Data); // BGE
			3'b110: taken = rs1Data < rs2Data; // BLTU
			3'b111: taken = rs1Data >= rs2Data; // BGEU
			default: taken = 1'b0;
		endcase
	end

	assign jumpTarget = {aluY[`RV_XLEN-1:1], 1'b0}; // JALR clears bit 0

	// Jump first, then taken branch, else sequential
	assign nextPc = jump ? jumpTarget :
		(branch && taken) ? pc + imm : pc + `RV_PC_INC;

endmodule

`default_nettype wire

// File: src/controlUnit.sv
`default_nettype none

module controlUnit (
	input  wire rvPkg::wordT instr,
	output rvPkg::aluOpT     aluOp,
	output rvPkg::immTypeT   immType,
	output logic             immSel, // ALU operand B is the immediate
	output logic             setDataZero, // ALU operand A forced to zero
	output logic             regWriteEnable,
	output logic             memRead,
	output logic             memWrite,
	output logic             branch,
	output logic             pcOperand, // ALU operand A is the PC
	output logic             jump,
	output logic             addConstant4, // Write back pc+4
	output rvPkg::memTypeT   memType
);
	import rvPkg::*;

	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opReg    = 7'b0110011;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       funct7b5; // SUB and SRA marker
	aluOpT      arithOp; // Operation from funct3

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7b5 = instr[30];

	//////////////////////////////////////////////////
	// funct3 to ALU operation
	//////////////////////////////////////////////////
	always_comb begin
		case (funct3)
			3'b000: arithOp = (funct7b5 && opcode == opReg) ? aluSub : aluAdd; // No SUBI
			3'b001: arithOp = aluSll;
			3'b010: arithOp = aluSlt;
			3'b011: arithOp = aluSltu;
			3'b100: arithOp = aluXor;
			3'b101: arithOp = funct7b5 ? aluSra : aluSrl; // R and I shift forms
			3'b110: arithOp = aluOr;
			default: arithOp = aluAnd;
		endcase
	end

	//////////////////////////////////////////////////
	// Opcode decode
	//////////////////////////////////////////////////
	always_comb begin
		aluOp = aluAdd; // Address and PC sums use ADD
		immType = iSext;
		immSel = 1'b0;
		setDataZero = 1'b0;
		regWriteEnable = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		branch = 1'b0;
		pcOperand = 1'b0;
		jump = 1'b0;
		addConstant4 = 1'b0;
		memType = memByte;
		case (opcode)
			opLui: begin
				setDataZero = 1'b1; // 0 + upper imm
				immSel = 1'b1;
				immType = uType;
				regWriteEnable = 1'b1;
			end
			opAuipc: begin
				pcOperand = 1'b1;
				immSel = 1'b1;
				immType = uType;
				regWriteEnable = 1'b1;
			end
			opJal: begin
				pcOperand = 1'b1; // Target pc+imm
				immSel = 1'b1;
				immType = jType;
				regWriteEnable = 1'b1;
				addConstant4 = 1'b1;
				jump = 1'b1;
			end
			opJalr: begin
				immSel = 1'b1; // Target rs1+imm
				immType = iSext;
				regWriteEnable = 1'b1;
				addConstant4 = 1'b1;
				jump = 1'b1;
			end
			opBranch: begin
				branch = 1'b1;
				immSel = 1'b1;
				immType = bType;
			end
			opLoad: begin
				// Address only, no load write-back in this slice
				immSel = 1'b1;
				immType = iSext;
				memRead = 1'b1;
				memType = memTypeT'(funct3);
			end
			opStore: begin
				immSel = 1'b1;
				immType = sType;
				memWrite = 1'b1;
				memType = memTypeT'(funct3);
			end
			opImm: begin
				immSel = 1'b1;
				immType = iSext;
				regWriteEnable = 1'b1;
				aluOp = arithOp;
			end
			opReg: begin
				regWriteEnable = 1'b1;
				aluOp = arithOp;
			end
			default: begin
				regWriteEnable = 1'b0; // Unsupported opcode, no side effects
			end
		endcase
	end

endmodule

`default_nettype wire

// File: src/immGen.sv
`default_nettype none

`include "rvSettings.svh"

module immGen (
	input  wire rvPkg::wordT    instr,
	input  wire rvPkg::immTypeT immType,
	output rvPkg::wordT         imm
);
	import rvPkg::*;

	logic signBit; // Instruction bit 31

	assign signBit = instr[31];

	always_comb begin
		case (immType)
			iSext: imm = {{(`RV_XLEN-12){signBit}}, instr[31:20]};
			iZext: imm = {{(`RV_XLEN-12){1'b0}}, instr[31:20]};
			sType: imm = {{(`RV_XLEN-12){signBit}}, instr[31:25], instr[11:7]};
			bType: begin
				// Offset in halfwords, bit 0 always zero
				imm = {{(`RV_XLEN-12){signBit}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			end
			uType: imm = {instr[31:12], 12'b0}; // Upper 20 bits
			jType: begin
				imm = {{(`RV_XLEN-20){signBit}}, instr[19:12], instr[20], instr[30:21],
					1'b0};
			end
			default: imm = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: src/regFile.sv
`default_nettype none

`include "rvSettings.svh"

module regFile (
	input  wire                 clk,
	input  wire                 rstN,
	input  wire                 we,
	input  wire rvPkg::regAddrT waddr,
	input  wire rvPkg::regAddrT raddr1,
	input  wire rvPkg::regAddrT raddr2,
	input  wire rvPkg::wordT    wdata,
	output rvPkg::wordT         rdata1,
	output rvPkg::wordT         rdata2
);
	import rvPkg::*;

	wordT regs [`RV_NREGS]; // Architectural registers

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin // x0 never written
			regs[waddr] <= wdata;
		end
	end

	// Combinational reads, x0 forced to zero
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: src/rvExecTop.sv
`default_nettype none

`include "rvSettings.svh"

module rvExecTop (
	input  wire                 clk,
	input  wire                 rstN,
	input  wire                 instrValid, // One-cycle strobe
	input  wire rvPkg::wordT    instr,
	input  wire rvPkg::wordT    pc,
	output logic                resultValid,
	output logic                rdWrite,
	output logic                memRead,
	output logic                memWrite,
	output rvPkg::regAddrT      rdAddr,
	output rvPkg::wordT         rdData,
	output rvPkg::wordT         memAddr,
	output rvPkg::wordT         storeData,
	output rvPkg::wordT         nextPc,
	output rvPkg::memTypeT      memType
);
	import rvPkg::*;

	aluOpT   aluOp;
	immTypeT immType;
	memTypeT decMemType;
	logic    immSel, setDataZero, regWriteEnable, decMemRead, decMemWrite;
	logic    branch, pcOperand, jump, addConstant4;
	logic    regWe; // Qualified register write
	regAddrT rs1, rs2, rd;
	wordT    imm, rs1Data, rs2Data, opA, opB, aluY, pcPlus4, wbData, nextPcC;

	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];

	//////////////////////////////////////////////////
	// Decode, operands and execute
	//////////////////////////////////////////////////
	controlUnit uCtrl (
		.instr(instr), .aluOp(aluOp), .immType(immType), .immSel(immSel),
		.setDataZero(setDataZero), .regWriteEnable(regWriteEnable), .memRead(decMemRead),
		.memWrite(decMemWrite), .branch(branch), .pcOperand(pcOperand), .jump(jump),
		.addConstant4(addConstant4), .memType(decMemType)
	);

	immGen uImm (.instr(instr), .immType(immType), .imm(imm));

	assign regWe = instrValid & regWriteEnable; // Write lands with the output edge

	regFile uRegs (
		.clk(clk), .rstN(rstN), .we(regWe), .waddr(rd), .raddr1(rs1), .raddr2(rs2),
		.wdata(wbData), .rdata1(rs1Data), .rdata2(rs2Data)
	);

	assign opA = pcOperand ? pc : (setDataZero ? '0 : rs1Data);
	assign opB = immSel ? imm : rs2Data;

	aluUnit uAlu (.op(aluOp), .a(opA), .b(opB), .y(aluY));

	assign pcPlus4 = pc + `RV_PC_INC;
	assign wbData = addConstant4 ? pcPlus4 : aluY; // Link value for JAL/JALR

	branchUnit uBranch (
		.funct3(instr[14:12]), .branch(branch), .jump(jump), .rs1Data(rs1Data),
		.rs2Data(rs2Data), .aluY(aluY), .pc(pc), .imm(imm), .nextPc(nextPcC)
	);

	//////////////////////////////////////////////////
	// Output registers
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			resultValid <= 1'b0;
			rdWrite <= 1'b0;
			memRead <= 1'b0;
			memWrite <= 1'b0;
		end else begin
			resultValid <= instrValid; // Low on idle cycles
			rdWrite <= regWe;
			memRead <= instrValid & decMemRead;
			memWrite <= instrValid & decMemWrite;
		end
	end

	always_ff @(posedge clk) begin
		if (instrValid) begin // Hold payload between strobes
			rdAddr <= rd;
			rdData <= wbData;
			memAddr <= aluY; // rs1+imm for loads and stores
			storeData <= rs2Data;
			nextPc <= nextPcC;
			memType <= decMemType;
		end
	end

endmodule

`default_nettype wire

// File: src/rvPkg.sv
`default_nettype none

`include "rvSettings.svh"

package rvPkg;

	typedef logic [`RV_XLEN-1:0] wordT; // Datapath word
	typedef logic [`RV_REGADDR-1:0] regAddrT; // Register index

	//////////////////////////////////////////////////
	// ALU operations, codes follow funct3 grouping
	//////////////////////////////////////////////////
	typedef enum logic [3:0] {
		aluAdd  = 4'd0,
		aluSub  = 4'd1,
		aluSll  = 4'd2,
		aluSlt  = 4'd3, // Signed compare
		aluSltu = 4'd4, // Unsigned compare
		aluXor  = 4'd5,
		aluSrl  = 4'd6,
		aluSra  = 4'd7,
		aluOr   = 4'd8,
		aluAnd  = 4'd9
	} aluOpT;

	// Immediate formats
	typedef enum logic [2:0] {
		iSext = 3'd0,
		iZext = 3'd1, // Zero-extended I form
		sType = 3'd2,
		bType = 3'd3,
		uType = 3'd4,
		jType = 3'd5
	} immTypeT;

	// Memory access size, same encoding as funct3
	typedef enum logic [2:0] {
		memByte  = 3'd0,
		memHalf  = 3'd1,
		memWord  = 3'd2,
		memByteU = 3'd4,
		memHalfU = 3'd5
	} memTypeT;

endpackage

`default_nettype wire

// File: src/rvSettings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Datapath word width
`define RV_XLEN 32

// Architectural register count and index width
`define RV_NREGS 32
`define RV_REGADDR 5

// Sequential PC step, one 32-bit instruction
`define RV_PC_INC 4

`endif
